// File: hdl/cop_pkg.sv
//========================================
// Shared sizes, opcodes and decode codes
// Referenced by scoped name from RTL and testbench
//========================================
`default_nettype none

package cop_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_CREGS = 16;
    localparam int CREG_W    = 4;      // Coprocessor register index width

    // RISC-V custom-0 major opcode
    localparam logic [6:0] COP_OPCODE = 7'b000_1011;

    // Minor op field, insn[31:28]
    localparam logic [3:0] OP_PADD    = 4'h0;
    localparam logic [3:0] OP_PSUB    = 4'h1;
    localparam logic [3:0] OP_PSLL_I  = 4'h2;
    localparam logic [3:0] OP_PSRL_I  = 4'h3;
    localparam logic [3:0] OP_GPR2XCR = 4'h4;
    localparam logic [3:0] OP_XCR2GPR = 4'h5;
    localparam logic [3:0] OP_CMOV_T  = 4'h6;
    localparam logic [3:0] OP_LD_LIU  = 4'h7;
    localparam logic [3:0] OP_LD_HIU  = 4'h8;

    // Instruction classes
    localparam logic [3:0] ICLASS_PACKED_ARITH = 4'h1;
    localparam logic [3:0] ICLASS_MOVE         = 4'h6;
    localparam logic [3:0] ICLASS_BITWISE      = 4'h8;

    // Subclasses, only meaningful together with the class
    localparam logic [4:0] SCLASS_PADD    = 5'd1;
    localparam logic [4:0] SCLASS_PSUB    = 5'd2;
    localparam logic [4:0] SCLASS_PSLL_I  = 5'd3;
    localparam logic [4:0] SCLASS_PSRL_I  = 5'd4;

    localparam logic [4:0] SCLASS_GPR2XCR = 5'd1;
    localparam logic [4:0] SCLASS_XCR2GPR = 5'd2;
    localparam logic [4:0] SCLASS_CMOV_T  = 5'd3;

    localparam logic [4:0] SCLASS_LD_LIU  = 5'd1;
    localparam logic [4:0] SCLASS_LD_HIU  = 5'd2;

    // Pack widths, codes above PW_2 are illegal
    localparam logic [2:0] PW_32 = 3'd0;
    localparam logic [2:0] PW_16 = 3'd1;
    localparam logic [2:0] PW_8  = 3'd2;
    localparam logic [2:0] PW_4  = 3'd3;
    localparam logic [2:0] PW_2  = 3'd4;

    // Register-operand layout
    typedef struct packed {
        logic [3:0] op;
        logic [2:0] pw;
        logic       rsvd;      // Bit 24
        logic [3:0] crs2;
        logic [3:0] crs1;      // Also GPR rs1 for GPR2XCR
        logic [3:0] shamt;
        logic [3:0] crd;
        logic       b7;        // Low bit of GPR rd
        logic [6:0] opcode;
    } cop_insn_reg_t;

    // Load-immediate layout
    typedef struct packed {
        logic [3:0]  op;
        logic [15:0] imm16;
        logic [3:0]  crd;
        logic        b7;
        logic [6:0]  opcode;
    } cop_insn_imm_t;

    typedef union packed {
        cop_insn_reg_t r;
        cop_insn_imm_t i;
    } cop_insn_u;

endpackage

`default_nettype wire

// File: hdl/cop_idecode.sv
//========================================
// Combinational instruction decoder
// Gives class, operands, immediate, illegal flag
//========================================
`default_nettype none

module cop_idecode (
    input  cop_pkg::cop_insn_u            insn_i,
    output logic [3:0]                    class_o,
    output logic [4:0]                    subclass_o,
    output logic [2:0]                    pw_o,
    output logic [cop_pkg::CREG_W-1:0]    crs1_o,
    output logic [cop_pkg::CREG_W-1:0]    crs2_o,
    output logic [cop_pkg::CREG_W-1:0]    crs3_o,
    output logic [cop_pkg::CREG_W-1:0]    crd_o,
    output logic [4:0]                    rd_o,
    output logic [cop_pkg::XLEN-1:0]      imm_o,
    output logic                          exception_o
);

    wire [3:0] op       = insn_i.r.op;
    wire       major_ok = insn_i.r.opcode == cop_pkg::COP_OPCODE;

    // One strobe per known instruction
    wire dec_padd    = major_ok && op == cop_pkg::OP_PADD;
    wire dec_psub    = major_ok && op == cop_pkg::OP_PSUB;
    wire dec_psll_i  = major_ok && op == cop_pkg::OP_PSLL_I;
    wire dec_psrl_i  = major_ok && op == cop_pkg::OP_PSRL_I;
    wire dec_gpr2xcr = major_ok && op == cop_pkg::OP_GPR2XCR;
    wire dec_xcr2gpr = major_ok && op == cop_pkg::OP_XCR2GPR;
    wire dec_cmov_t  = major_ok && op == cop_pkg::OP_CMOV_T;
    wire dec_ld_liu  = major_ok && op == cop_pkg::OP_LD_LIU;
    wire dec_ld_hiu  = major_ok && op == cop_pkg::OP_LD_HIU;

    wire class_packed_arith = dec_padd || dec_psub || dec_psll_i || dec_psrl_i;
    wire class_move         = dec_gpr2xcr || dec_xcr2gpr || dec_cmov_t;
    wire class_bitwise      = dec_ld_liu || dec_ld_hiu;

    assign class_o =
        {4{class_packed_arith}} & cop_pkg::ICLASS_PACKED_ARITH |
        {4{class_move        }} & cop_pkg::ICLASS_MOVE         |
        {4{class_bitwise     }} & cop_pkg::ICLASS_BITWISE      ;

    assign subclass_o =
        {5{dec_padd   }} & cop_pkg::SCLASS_PADD    |
        {5{dec_psub   }} & cop_pkg::SCLASS_PSUB    |
        {5{dec_psll_i }} & cop_pkg::SCLASS_PSLL_I  |
        {5{dec_psrl_i }} & cop_pkg::SCLASS_PSRL_I  |
        {5{dec_gpr2xcr}} & cop_pkg::SCLASS_GPR2XCR |
        {5{dec_xcr2gpr}} & cop_pkg::SCLASS_XCR2GPR |
        {5{dec_cmov_t }} & cop_pkg::SCLASS_CMOV_T  |
        {5{dec_ld_liu }} & cop_pkg::SCLASS_LD_LIU  |
        {5{dec_ld_hiu }} & cop_pkg::SCLASS_LD_HIU  ;

    // Register fields
    assign pw_o   = insn_i.r.pw;
    assign crs1_o = insn_i.r.crs1;
    assign crs2_o = insn_i.r.crs2;
    assign crd_o  = insn_i.r.crd;
    assign rd_o   = {insn_i.r.crd, insn_i.r.b7};  // GPR rd sits in 11:7

    // Old destination value is read through the third port
    wire crd_in_crs3 = dec_cmov_t || dec_ld_liu || dec_ld_hiu;

    assign crs3_o = crd_in_crs3 ? insn_i.r.crd : '0;

    // Immediates, both zero extended
    wire imm_sh = dec_psll_i || dec_psrl_i;
    wire imm_li = dec_ld_liu || dec_ld_hiu;

    wire [cop_pkg::XLEN-1:0] imm_sh_val = {{(cop_pkg::XLEN-4){1'b0}}, insn_i.r.shamt};
    wire [cop_pkg::XLEN-1:0] imm_li_val = {{(cop_pkg::XLEN-16){1'b0}}, insn_i.i.imm16};

    assign imm_o =
        {cop_pkg::XLEN{imm_sh}} & imm_sh_val |
        {cop_pkg::XLEN{imm_li}} & imm_li_val ;

    // Unknown opcode or minor op
    wire dec_invalid = !(class_packed_arith || class_move || class_bitwise);

    wire bad_pack_width = class_packed_arith && (insn_i.r.pw > cop_pkg::PW_2);

    assign exception_o = dec_invalid || bad_pack_width;

endmodule

`default_nettype wire

// File: hdl/cop_regfile.sv
//========================================
// Coprocessor register file, 3 reads 1 write
//========================================
`default_nettype none

module cop_regfile (
    input  logic                          g_clk_i,
    input  logic                          rst_n_i,
    input  logic [cop_pkg::CREG_W-1:0]    rs1_addr_i,
    input  logic [cop_pkg::CREG_W-1:0]    rs2_addr_i,
    input  logic [cop_pkg::CREG_W-1:0]    rs3_addr_i,
    input  logic                          wen_i,
    input  logic [cop_pkg::CREG_W-1:0]    waddr_i,
    input  logic [cop_pkg::XLEN-1:0]      wdata_i,
    output logic [cop_pkg::XLEN-1:0]      rs1_data_o,
    output logic [cop_pkg::XLEN-1:0]      rs2_data_o,
    output logic [cop_pkg::XLEN-1:0]      rs3_data_o
);

    logic [cop_pkg::XLEN-1:0] regs [cop_pkg::NUM_CREGS];

    always_ff @(posedge g_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cop_pkg::NUM_CREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the old value during a write cycle
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];
    assign rs3_data_o = regs[rs3_addr_i];

endmodule

`default_nettype wire

// File: hdl/cop_execute.sv
//========================================
// Packed ALU, moves and immediate loads
// Registers completion one cycle after accept
//========================================
`default_nettype none

module cop_execute (
    input  logic                          g_clk_i,
    input  logic                          rst_n_i,
    input  logic                          valid_i,
    input  logic [3:0]                    class_i,
    input  logic [4:0]                    subclass_i,
    input  logic [2:0]                    pw_i,
    input  logic                          exception_i,
    input  logic [cop_pkg::CREG_W-1:0]    crd_i,
    input  logic [4:0]                    rd_i,
    input  logic [cop_pkg::XLEN-1:0]      imm_i,
    input  logic [cop_pkg::XLEN-1:0]      crs1_data_i,
    input  logic [cop_pkg::XLEN-1:0]      crs2_data_i,
    input  logic [cop_pkg::XLEN-1:0]      crs3_data_i,
    input  logic [cop_pkg::XLEN-1:0]      rs1_value_i,
    output logic                          creg_wen_o,
    output logic [cop_pkg::CREG_W-1:0]    creg_waddr_o,
    output logic [cop_pkg::XLEN-1:0]      creg_wdata_o,
    output logic                          done_o,
    output logic                          exception_o,
    output logic                          gpr_wen_o,
    output logic [4:0]                    gpr_rd_o,
    output logic [cop_pkg::XLEN-1:0]      gpr_wdata_o
);

    wire is_parith  = class_i == cop_pkg::ICLASS_PACKED_ARITH;
    wire is_move    = class_i == cop_pkg::ICLASS_MOVE;
    wire is_bitwise = class_i == cop_pkg::ICLASS_BITWISE;

    wire op_padd    = is_parith  && subclass_i == cop_pkg::SCLASS_PADD;
    wire op_psub    = is_parith  && subclass_i == cop_pkg::SCLASS_PSUB;
    wire op_psll    = is_parith  && subclass_i == cop_pkg::SCLASS_PSLL_I;
    wire op_psrl    = is_parith  && subclass_i == cop_pkg::SCLASS_PSRL_I;
    wire op_gpr2xcr = is_move    && subclass_i == cop_pkg::SCLASS_GPR2XCR;
    wire op_xcr2gpr = is_move    && subclass_i == cop_pkg::SCLASS_XCR2GPR;
    wire op_cmov    = is_move    && subclass_i == cop_pkg::SCLASS_CMOV_T;
    wire op_liu     = is_bitwise && subclass_i == cop_pkg::SCLASS_LD_LIU;
    wire op_hiu     = is_bitwise && subclass_i == cop_pkg::SCLASS_LD_HIU;

    wire [3:0] shamt = imm_i[3:0];

    int                       lane_w;
    logic [cop_pkg::XLEN-1:0] lane_msb;   // Top bit of every lane
    logic [cop_pkg::XLEN-1:0] keep_sll;   // Bits left after a per-lane left shift
    logic [cop_pkg::XLEN-1:0] keep_srl;
    logic [cop_pkg::XLEN-1:0] result;

    always_comb begin
        case (pw_i)
            cop_pkg::PW_32: lane_w = 32;
            cop_pkg::PW_16: lane_w = 16;
            cop_pkg::PW_8:  lane_w = 8;
            cop_pkg::PW_4:  lane_w = 4;
            cop_pkg::PW_2:  lane_w = 2;
            default:        lane_w = 32;  // Flagged illegal by decode
        endcase
    end

    // Lane widths are powers of two, so position is a mask
    always_comb begin
        for (int i = 0; i < cop_pkg::XLEN; i++) begin
            lane_msb[i] = (i & (lane_w - 1)) == lane_w - 1;
            keep_sll[i] = (i & (lane_w - 1)) >= int'(shamt);
            keep_srl[i] = (i & (lane_w - 1)) + int'(shamt) < lane_w;
        end
    end

    wire [cop_pkg::XLEN-1:0] a = crs1_data_i;
    wire [cop_pkg::XLEN-1:0] b = crs2_data_i;

    // Lane msb handled apart so no carry or borrow crosses lanes
    wire [cop_pkg::XLEN-1:0] p_add =
        ((a & ~lane_msb) + (b & ~lane_msb)) ^ ((a ^ b) & lane_msb);
    wire [cop_pkg::XLEN-1:0] p_sub =
        ((a | lane_msb) - (b & ~lane_msb)) ^ ((a ^ ~b) & lane_msb);

    wire [cop_pkg::XLEN-1:0] p_sll = (a << shamt) & keep_sll;
    wire [cop_pkg::XLEN-1:0] p_srl = (a >> shamt) & keep_srl;

    always_comb begin
        if (op_padd)         result = p_add;
        else if (op_psub)    result = p_sub;
        else if (op_psll)    result = p_sll;
        else if (op_psrl)    result = p_srl;
        else if (op_gpr2xcr) result = rs1_value_i;
        else if (op_cmov)    result = |b ? a : crs3_data_i;  // Else keep old crd
        else if (op_liu)     result = {crs3_data_i[31:16], imm_i[15:0]};
        else if (op_hiu)     result = {imm_i[15:0], crs3_data_i[15:0]};
        else                 result = '0;
    end

    wire writes_creg = op_padd || op_psub || op_psll || op_psrl ||
                       op_gpr2xcr || op_cmov || op_liu || op_hiu;

    assign creg_wen_o   = valid_i && !exception_i && writes_creg;
    assign creg_waddr_o = crd_i;
    assign creg_wdata_o = result;

    always_ff @(posedge g_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o      <= 1'b0;
            exception_o <= 1'b0;
            gpr_wen_o   <= 1'b0;
        end else begin
            done_o      <= valid_i;
            exception_o <= valid_i && exception_i;
            gpr_wen_o   <= valid_i && !exception_i && op_xcr2gpr;
        end
    end

    // GPR write-back payload, qualified by gpr_wen_o
    always_ff @(posedge g_clk_i) begin
        if (valid_i) begin
            gpr_rd_o    <= rd_i;
            gpr_wdata_o <= crs1_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cop_top.sv
//========================================
// Coprocessor top level
// Decoder, register file and execute stage
//========================================
`default_nettype none

module cop_top (
    input  logic                        g_clk_i,
    input  logic                        rst_n_i,
    input  logic                        insn_valid_i,   // One strobe per insn
    input  cop_pkg::cop_insn_u          insn_i,
    input  logic [cop_pkg::XLEN-1:0]    rs1_value_i,
    output logic                        done_o,
    output logic                        exception_o,
    output logic                        gpr_wen_o,
    output logic [4:0]                  gpr_rd_o,
    output logic [cop_pkg::XLEN-1:0]    gpr_wdata_o
);

    logic [3:0]                    id_class;
    logic [4:0]                    id_subclass;
    logic [2:0]                    id_pw;
    logic [cop_pkg::CREG_W-1:0]    id_crs1;
    logic [cop_pkg::CREG_W-1:0]    id_crs2;
    logic [cop_pkg::CREG_W-1:0]    id_crs3;
    logic [cop_pkg::CREG_W-1:0]    id_crd;
    logic [4:0]                    id_rd;
    logic [cop_pkg::XLEN-1:0]      id_imm;
    logic                          id_exception;

    logic [cop_pkg::XLEN-1:0]      rf_rs1_data;
    logic [cop_pkg::XLEN-1:0]      rf_rs2_data;
    logic [cop_pkg::XLEN-1:0]      rf_rs3_data;

    logic                          ex_creg_wen;
    logic [cop_pkg::CREG_W-1:0]    ex_creg_waddr;
    logic [cop_pkg::XLEN-1:0]      ex_creg_wdata;

    cop_idecode i_cop_idecode (
        .insn_i      (insn_i),
        .class_o     (id_class),
        .subclass_o  (id_subclass),
        .pw_o        (id_pw),
        .crs1_o      (id_crs1),
        .crs2_o      (id_crs2),
        .crs3_o      (id_crs3),
        .crd_o       (id_crd),
        .rd_o        (id_rd),
        .imm_o       (id_imm),
        .exception_o (id_exception)
    );

    cop_regfile i_cop_regfile (
        .g_clk_i    (g_clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (id_crs1),
        .rs2_addr_i (id_crs2),
        .rs3_addr_i (id_crs3),
        .wen_i      (ex_creg_wen),
        .waddr_i    (ex_creg_waddr),
        .wdata_i    (ex_creg_wdata),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .rs3_data_o (rf_rs3_data)
    );

    cop_execute i_cop_execute (
        .g_clk_i      (g_clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (insn_valid_i),
        .class_i      (id_class),
        .subclass_i   (id_subclass),
        .pw_i         (id_pw),
        .exception_i  (id_exception),
        .crd_i        (id_crd),
        .rd_i         (id_rd),
        .imm_i        (id_imm),
        .crs1_data_i  (rf_rs1_data),
        .crs2_data_i  (rf_rs2_data),
        .crs3_data_i  (rf_rs3_data),
        .rs1_value_i  (rs1_value_i),
        .creg_wen_o   (ex_creg_wen),
        .creg_waddr_o (ex_creg_waddr),
        .creg_wdata_o (ex_creg_wdata),
        .done_o       (done_o),
        .exception_o  (exception_o),
        .gpr_wen_o    (gpr_wen_o),
        .gpr_rd_o     (gpr_rd_o),
        .gpr_wdata_o  (gpr_wdata_o)
    );

endmodule

`default_nettype wire

// File: sim/cop_chk.sv
//========================================
// Assertions on the execute stage
// Bound into cop_execute by the testbench
//========================================
`default_nettype none

module cop_chk (
    input logic g_clk_i,
    input logic rst_n_i,
    input logic valid_i,
    input logic exception_i,
    input logic creg_wen_i,
    input logic done_i,
    input logic exc_out_i,
    input logic gpr_wen_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Two cycles of done need two strobes in a row
    done_hold: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        done_i && $past(done_i) |-> $past(valid_i) && $past(valid_i, 2))
    else begin
        fail_count++;
        $error("done_o stayed high without back-to-back strobes");
    end

    gpr_wen_legal: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        gpr_wen_i |-> done_i && !exc_out_i)
    else begin
        fail_count++;
        $error("gpr_wen_o high without done_o or with exception_o");
    end

    // Illegal instructions never touch the register file
    no_write_on_exc: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
        exception_i |-> !creg_wen_i)
    else begin
        fail_count++;
        $error("Coprocessor register written during an illegal instruction");
    end

endmodule

`default_nettype wire

// File: sim/tb_cop.sv
//========================================
// Testbench for the coprocessor top level
// Replays the stimulus file with one instruction per test
//========================================
`default_nettype none

module tb_cop;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NAME_W     = 8 * 24;
    localparam int LINE_W     = 8 * 160;
    localparam int CLK_PERIOD = 20;

    logic                        g_clk;
    logic                        rst_n;
    logic                        insn_valid;
    cop_pkg::cop_insn_u          insn;
    logic [cop_pkg::XLEN-1:0]    rs1_value;
    logic                        done;
    logic                        exception;
    logic                        gpr_wen;
    logic [4:0]                  gpr_rd;
    logic [cop_pkg::XLEN-1:0]    gpr_wdata;

    // One table entry per data line of the stimulus file
    logic [NAME_W-1:0]           t_name [$];
    logic [31:0]                 t_insn [$];
    logic [cop_pkg::XLEN-1:0]    t_rs1 [$];
    logic                        t_exc [$];
    logic                        t_wen [$];
    logic [cop_pkg::XLEN-1:0]    t_wdata [$];

    int errors;
    int test_errs;
    int failed_tests;
    bit loaded;

    cop_top i_cop_top (
        .g_clk_i      (g_clk),
        .rst_n_i      (rst_n),
        .insn_valid_i (insn_valid),
        .insn_i       (insn),
        .rs1_value_i  (rs1_value),
        .done_o       (done),
        .exception_o  (exception),
        .gpr_wen_o    (gpr_wen),
        .gpr_rd_o     (gpr_rd),
        .gpr_wdata_o  (gpr_wdata)
    );

    bind cop_execute cop_chk i_cop_chk (
        .g_clk_i     (g_clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .exception_i (exception_i),
        .creg_wen_i  (creg_wen_o),
        .done_i      (done_o),
        .exc_out_i   (exception_o),
        .gpr_wen_i   (gpr_wen_o)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    task automatic load_stim();
        int                fd;
        int                n;
        logic [LINE_W-1:0] line;
        logic [NAME_W-1:0] name;
        logic [31:0]       insn_w;
        logic [31:0]       rs1_w;
        logic [31:0]       exc_w;
        logic [31:0]       wen_w;
        logic [31:0]       wdata_w;
        fd = $fopen("sim/cop_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/cop_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            // Comment and blank lines never yield six fields
            n = $sscanf(line, "%s %h %h %h %h %h",
                        name, insn_w, rs1_w, exc_w, wen_w, wdata_w);
            if (n == 6) begin
                t_name.push_back(name);
                t_insn.push_back(insn_w);
                t_rs1.push_back(rs1_w);
                t_exc.push_back(exc_w[0]);
                t_wen.push_back(wen_w[0]);
                t_wdata.push_back(wdata_w);
            end
        end
        $fclose(fd);
    endtask

    task automatic verify_flag(input string test, input string what,
                               input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %0s %0s expected %0b actual %0b", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_data(input string test, input string what,
                                input logic [cop_pkg::XLEN-1:0] exp,
                                input logic [cop_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("Error: %0s %0s expected %h actual %h", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_gpr_index(input string test, input string what,
                                   input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("Error: %0s %0s expected %0d actual %0d", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic run_test(input int idx);
        string      name;
        logic [4:0] exp_rd;
        name      = $sformatf("%0s", t_name[idx]);
        exp_rd    = t_insn[idx][11:7];   // GPR rd field of XCR2GPR
        test_errs = 0;
        @(posedge g_clk);
        #2;
        insn_valid = 1'b1;
        insn       = t_insn[idx];
        rs1_value  = t_rs1[idx];
        @(posedge g_clk);                // Accepting edge
        #2;
        insn_valid = 1'b0;
        // Result is due in the cycle right after the accepting edge
        if (!done) begin
            $display("Test %0s: done_o did not pulse in the cycle after the strobe", name);
            test_errs++;
        end else begin
            verify_flag(name, "exception_o", t_exc[idx], exception);
            verify_flag(name, "gpr_wen_o", t_wen[idx], gpr_wen);
            if (t_wen[idx]) begin
                check_gpr_index(name, "gpr_rd_o", exp_rd, gpr_rd);
                compare_data(name, "gpr_wdata_o", t_wdata[idx], gpr_wdata);
            end
        end
        errors += test_errs;
        if (test_errs == 0) begin
            $display("Test %0s ok", name);
        end else begin
            failed_tests++;
            $display("Test %0s failed with %0d errors", name, test_errs);
        end
    endtask

    // Watchdog allows four cycles per test plus slack
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(t_name.size()) + 10) * CLK_PERIOD * 4;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int asrt_fails;
        rst_n        = 1'b0;
        insn_valid   = 1'b0;
        insn         = '0;
        rs1_value    = '0;
        errors       = 0;
        test_errs    = 0;
        failed_tests = 0;
        load_stim();
        loaded = 1'b1;
        if (t_name.size() == 0) begin
            $display("No tests found in the stimulus file");
            errors++;
        end
        repeat (3) @(posedge g_clk);
        #2;
        rst_n = 1'b1;
        foreach (t_name[i]) begin
            run_test(i);
        end
        asrt_fails = int'(i_cop_top.i_cop_execute.i_cop_chk.fail_count);
        errors += asrt_fails;
        $display("%0d tests run, %0d failed, %0d assertion failures",
                 t_name.size(), failed_tests, asrt_fails);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/cop_stim.txt
# test name, instruction, rs1 value, expected exception, gpr_wen, gpr_wdata (hex)
# expected gpr_wdata only matters when gpr_wen is 1
wr_c1            4000010b 12345678 0 0 00000000
wr_c2            4000020b 89abcdef 0 0 00000000
rd_c1_x5         5001028b 00000000 0 1 12345678
rd_c2_x31        50020f8b 00000000 0 1 89abcdef
padd_pw32        0021040b 00000000 0 0 00000000
rd_padd_pw32     5004050b 00000000 0 1 9be02467
padd_pw16        0221040b 00000000 0 0 00000000
rd_padd_pw16     5004050b 00000000 0 1 9bdf2467
padd_pw8         0421040b 00000000 0 0 00000000
rd_padd_pw8      5004050b 00000000 0 1 9bdf2367
padd_pw4         0621040b 00000000 0 0 00000000
rd_padd_pw4      5004050b 00000000 0 1 9bdf1357
padd_pw2         0821040b 00000000 0 0 00000000
rd_padd_pw2      5004050b 00000000 0 1 9b9f1317
psub_pw32        1021040b 00000000 0 0 00000000
rd_psub_pw32     5004050b 00000000 0 1 88888889
psub_pw16        1221040b 00000000 0 0 00000000
rd_psub_pw16     5004050b 00000000 0 1 88898889
psub_pw8         1421040b 00000000 0 0 00000000
rd_psub_pw8      5004050b 00000000 0 1 89898989
psub_pw4         1621040b 00000000 0 0 00000000
rd_psub_pw4      5004050b 00000000 0 1 99999999
psub_pw2         1821040b 00000000 0 0 00000000
rd_psub_pw2      5004050b 00000000 0 1 999d999d
psll_pw8_s3      2401340b 00000000 0 0 00000000
rd_psll_pw8      5004050b 00000000 0 1 90a0b0c0
psrl_pw4_s1      3602140b 00000000 0 0 00000000
rd_psrl_pw4      5004050b 00000000 0 1 44556677
ld_liu_c1        7beef10b 00000000 0 0 00000000
rd_liu_c1        5001028b 00000000 0 1 1234beef
ld_hiu_c2        8cafe20b 00000000 0 0 00000000
rd_hiu_c2        50020f8b 00000000 0 1 cafecdef
cmov_nz          6021040b 00000000 0 0 00000000
rd_cmov_nz       5004050b 00000000 0 1 1234beef
cmov_z           6002040b 00000000 0 0 00000000
rd_cmov_z        5004050b 00000000 0 1 1234beef
padd_pw5         0a21040b 00000000 1 0 00000000
padd_pw6         0c21040b 00000000 1 0 00000000
padd_pw7         0e21040b 00000000 1 0 00000000
bad_minor        9000040b deadbeef 1 0 00000000
bad_major        4000042b deadbeef 1 0 00000000
bad_major_rd     5004052b 00000000 1 0 00000000
rd_c4_kept       5004050b 00000000 0 1 1234beef

// File: all.f
hdl/cop_pkg.sv
hdl/cop_idecode.sv
hdl/cop_regfile.sv
hdl/cop_execute.sv
hdl/cop_top.sv
sim/cop_chk.sv
sim/tb_cop.sv

// File: run.sh
#!/bin/sh
# Compile and run the coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cop -f all.f -o tb_cop

out=$(./obj_dir/tb_cop +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
